// ==== include/sequencer_settings.svh ====
`ifndef SEQUENCER_SETTINGS_SVH
`define SEQUENCER_SETTINGS_SVH

// Control store addressing, 2K words
`define CRAM_ADDR_W 11

// Execution payload carried with each microword
`define PAYLOAD_W 16

// Condition flags seen by skip and dispatch
`define FLAG_W 16

// Return stack geometry
`define STACK_DEPTH 8
`define STACK_PTR_W 3
`define STACK_CNT_W 4

// Credits granted to the execution unit after reset
`define CREDIT_MAX 4
`define CREDIT_W 3

`endif

// ==== logic/addressSequencer.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module addressSequencer (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    advance,
  input  seqPkg::microWord        word,
  input  logic [`CRAM_ADDR_W-1:0] dispValue,
  input  logic                    skipBit,
  input  logic [`CRAM_ADDR_W-1:0] stackTop,
  input  logic [`STACK_CNT_W-1:0] depthCount,
  input  logic [1:0]              diagSel,
  output logic [`CRAM_ADDR_W-1:0] crAddr,
  output logic                    push,
  output logic                    pop,
  output logic [`CRAM_ADDR_W-1:0] pushAddr,
  output logic [`CRAM_ADDR_W-1:0] diagData
);

  import seqPkg::*;

  localparam int AW = `CRAM_ADDR_W;

  logic [AW-1:0] nextAddr;

  ////////////////////////////////////////////////////////////////////////////
  // Next address
  ////////////////////////////////////////////////////////////////////////////

  // Dispatch, skip and return values are ORed onto the jump field
  always_comb begin
    case (word.mode)
      NEXT_J:   nextAddr = word.jump;
      DISPATCH: nextAddr = word.jump | dispValue;
      SKIP:     nextAddr = word.jump | AW'(skipBit);
      CALL:     nextAddr = word.jump;
      RETURN:   nextAddr = word.jump | stackTop;
      FORCE:    nextAddr = '1;
      // Unused mode codes behave as a plain jump
      default:  nextAddr = word.jump;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      crAddr <= '0;
    end else if (advance) begin
      crAddr <= nextAddr;
    end
  end

  // Stack moves only when the word is actually issued
  assign push     = advance && (word.mode == CALL);
  assign pop      = advance && (word.mode == RETURN);
  assign pushAddr = crAddr;

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (diagSel)
      2'd0:    diagData = crAddr;
      2'd1:    diagData = stackTop;
      2'd2:    diagData = AW'(depthCount);
      default: diagData = dispValue;
    endcase
  end

endmodule

// ==== logic/cramStore.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module cramStore (
  input  logic                    CLK,
  input  logic                    cramWe,
  input  logic [`CRAM_ADDR_W-1:0] cramWAddr,
  input  seqPkg::microWord        cramWData,
  input  logic [`CRAM_ADDR_W-1:0] rdAddr,
  output seqPkg::microWord        rdWord
);

  import seqPkg::*;

  localparam int CRAM_WORDS = 1 << `CRAM_ADDR_W;

  ////////////////////////////////////////////////////////////////////////////
  // Control store array
  ////////////////////////////////////////////////////////////////////////////

  // Contents survive reset; the store is only loaded through the diag port
  microWord mem [CRAM_WORDS];

  // Diagnostic load, one word per clock while the sequencer is stopped
  always_ff @(posedge CLK) begin
    if (cramWe) begin
      mem[cramWAddr] <= cramWData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  // Asynchronous read at the current control address
  // The next address is formed from this word in the same cycle
  assign rdWord = mem[rdAddr];

endmodule

// ==== logic/dispatchCapture.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module dispatchCapture (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    opLoad,
  input  logic [`CRAM_ADDR_W-1:0] opDispatch,
  input  logic                    flagLoad,
  input  logic [`FLAG_W-1:0]      flags,
  input  logic                    diagAddrLoad,
  input  logic [`CRAM_ADDR_W-1:0] diagAddrIn,
  input  seqPkg::selField         sel,
  input  logic [`CRAM_ADDR_W-1:0] stackTop,
  output logic [`CRAM_ADDR_W-1:0] dispValue,
  output logic                    skipBit
);

  localparam int AW = `CRAM_ADDR_W;

  logic [AW-1:0]      opReg;
  logic [`FLAG_W-1:0] flagReg;
  logic [AW-1:0]      diagAddr;
  logic [AW-1:0]      srcWord;

  ////////////////////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      opReg    <= '0;
      flagReg  <= '0;
      diagAddr <= '0;
    end else begin
      if (opLoad) begin
        opReg <= opDispatch;
      end
      if (flagLoad) begin
        flagReg <= flags;
      end
      if (diagAddrLoad) begin
        diagAddr <= diagAddrIn;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch source and placement
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sel.disp.dispSrc)
      3'd0:    srcWord = diagAddr;
      3'd1:    srcWord = opReg;
      3'd2:    srcWord = AW'(opReg[3:0]);
      3'd3:    srcWord = AW'(flagReg[3:0]);
      3'd4:    srcWord = AW'(flagReg[7:4]);
      3'd5:    srcWord = AW'(flagReg[11:8]);
      3'd6:    srcWord = AW'(flagReg[15:12]);
      default: srcWord = AW'(stackTop[3:0]);
    endcase
  end

  // Shift codes 0..2 place the low nibble; code 3 passes the full source
  always_comb begin
    case (sel.disp.dispShift)
      2'd0:    dispValue = AW'(srcWord[3:0]);
      2'd1:    dispValue = AW'(srcWord[3:0]) << 4;
      2'd2:    dispValue = AW'(srcWord[3:0]) << 7;
      default: dispValue = srcWord;
    endcase
  end

  // Skip condition, only meaningful for SKIP words
  assign skipBit = flagReg[sel.skip.skipCond] ^ sel.skip.skipInvert;

endmodule

// ==== logic/issueCredit.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module issueCredit (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    run,
  input  logic                    creditReturn,
  input  logic [`CRAM_ADDR_W-1:0] crAddr,
  input  seqPkg::microWord        word,
  output logic                    advance,
  output logic                    uValid,
  output logic [`CRAM_ADDR_W-1:0] uAddr,
  output logic [`PAYLOAD_W-1:0]   uPayload,
  output logic                    uParity
);

  logic [`CREDIT_W-1:0] credits;

  // Issue whenever running and the execution unit has room
  assign advance = run && (credits != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      credits <= `CREDIT_W'(`CREDIT_MAX);
    end else begin
      case ({advance, creditReturn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        // Issue and return together cancel out
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Microword output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      uValid <= 1'b0;
    end else begin
      uValid <= advance;
    end
  end

  // Held between issues, qualified by uValid
  always_ff @(posedge CLK) begin
    if (advance) begin
      uAddr    <= crAddr;
      uPayload <= word.payload;
      uParity  <= ^{word.mode, word.sel};
    end
  end

endmodule

// ==== logic/microSequencer.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module microSequencer (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    cramWe,
  input  logic [`CRAM_ADDR_W-1:0] cramWAddr,
  input  seqPkg::microWord        cramWData,
  input  logic                    opLoad,
  input  logic [`CRAM_ADDR_W-1:0] opDispatch,
  input  logic                    flagLoad,
  input  logic [`FLAG_W-1:0]      flags,
  input  logic                    diagAddrLoad,
  input  logic [`CRAM_ADDR_W-1:0] diagAddrIn,
  input  logic                    run,
  input  logic                    creditReturn,
  input  logic [1:0]              diagSel,
  output logic                    uValid,
  output logic [`CRAM_ADDR_W-1:0] uAddr,
  output logic [`PAYLOAD_W-1:0]   uPayload,
  output logic                    uParity,
  output logic [`CRAM_ADDR_W-1:0] diagData
);

  import seqPkg::*;

  microWord                word;
  logic [`CRAM_ADDR_W-1:0] crAddr;
  logic [`CRAM_ADDR_W-1:0] dispValue;
  logic                    skipBit;
  logic [`CRAM_ADDR_W-1:0] stackTop;
  logic [`STACK_CNT_W-1:0] depthCount;
  logic                    push;
  logic                    pop;
  logic [`CRAM_ADDR_W-1:0] pushAddr;
  logic                    advance;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  dispatchCapture capture (
    .CLK          (CLK),
    .RESET        (RESET),
    .opLoad       (opLoad),
    .opDispatch   (opDispatch),
    .flagLoad     (flagLoad),
    .flags        (flags),
    .diagAddrLoad (diagAddrLoad),
    .diagAddrIn   (diagAddrIn),
    .sel          (word.sel),
    .stackTop     (stackTop),
    .dispValue    (dispValue),
    .skipBit      (skipBit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Address loop: sequencer, stack and store
  ////////////////////////////////////////////////////////////////////////////

  addressSequencer sequencer (
    .CLK        (CLK),
    .RESET      (RESET),
    .advance    (advance),
    .word       (word),
    .dispValue  (dispValue),
    .skipBit    (skipBit),
    .stackTop   (stackTop),
    .depthCount (depthCount),
    .diagSel    (diagSel),
    .crAddr     (crAddr),
    .push       (push),
    .pop        (pop),
    .pushAddr   (pushAddr),
    .diagData   (diagData)
  );

  returnStack stack (
    .CLK        (CLK),
    .RESET      (RESET),
    .push       (push),
    .pop        (pop),
    .pushAddr   (pushAddr),
    .top        (stackTop),
    .depthCount (depthCount)
  );

  cramStore store (
    .CLK       (CLK),
    .cramWe    (cramWe),
    .cramWAddr (cramWAddr),
    .cramWData (cramWData),
    .rdAddr    (crAddr),
    .rdWord    (word)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  issueCredit issue (
    .CLK          (CLK),
    .RESET        (RESET),
    .run          (run),
    .creditReturn (creditReturn),
    .crAddr       (crAddr),
    .word         (word),
    .advance      (advance),
    .uValid       (uValid),
    .uAddr        (uAddr),
    .uPayload     (uPayload),
    .uParity      (uParity)
  );

endmodule

// ==== logic/returnStack.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module returnStack (
  input  logic                    CLK,
  input  logic                    RESET,
  input  logic                    push,
  input  logic                    pop,
  input  logic [`CRAM_ADDR_W-1:0] pushAddr,
  output logic [`CRAM_ADDR_W-1:0] top,
  output logic [`STACK_CNT_W-1:0] depthCount
);

  localparam int DEPTH = `STACK_DEPTH;

  logic [`CRAM_ADDR_W-1:0] entries [DEPTH];
  // Points at the slot the next push writes
  logic [`STACK_PTR_W-1:0] ptr;
  logic [`STACK_PTR_W-1:0] ptrPrev;

  assign ptrPrev = (ptr == '0) ? `STACK_PTR_W'(DEPTH - 1) : ptr - 1'b1;

  always_ff @(posedge CLK) begin
    if (push) begin
      entries[ptr] <= pushAddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      ptr        <= '0;
      depthCount <= '0;
    end else if (push) begin
      ptr <= (ptr == `STACK_PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
      // A full stack keeps its count, the oldest entry is overwritten
      if (depthCount != `STACK_CNT_W'(DEPTH)) begin
        depthCount <= depthCount + 1'b1;
      end
    end else if (pop && depthCount != '0) begin
      ptr        <= ptrPrev;
      depthCount <= depthCount - 1'b1;
    end
  end

  // Empty stack returns to address zero
  assign top = (depthCount == '0) ? '0 : entries[ptrPrev];

endmodule

// ==== logic/seqPkg.sv ====
`include "sequencer_settings.svh"

package seqPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Next-address modes of a microword
  ////////////////////////////////////////////////////////////////////////////

  // FORCE sends the sequencer to the all-ones trap address
  typedef enum logic [2:0] {
    NEXT_J   = 3'd0,
    DISPATCH = 3'd1,
    SKIP     = 3'd2,
    CALL     = 3'd3,
    RETURN   = 3'd4,
    FORCE    = 3'd5
  } seqMode;

  ////////////////////////////////////////////////////////////////////////////
  // Select field, read one of two ways depending on mode
  ////////////////////////////////////////////////////////////////////////////

  // Dispatch reading: source number and placement of the value
  typedef struct packed {
    logic [2:0] dispSrc;
    logic [1:0] dispShift;
  } dispatchView;

  // Skip reading: flag index and optional inversion
  typedef struct packed {
    logic       skipInvert;
    logic [3:0] skipCond;
  } skipView;

  typedef union packed {
    dispatchView disp;
    skipView     skip;
  } selField;

  // One control store word, 35 bits
  typedef struct packed {
    logic [`CRAM_ADDR_W-1:0] jump;
    seqMode                  mode;
    selField                 sel;
    logic [`PAYLOAD_W-1:0]   payload;
  } microWord;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build the microsequencer testbench with Verilator, run it and look for the pass line
verilator --binary --timing -f vlog.f --top-module seqTb -o seqSim || {
  echo "Verilator build failed"
  exit 1
}
simOut=$(./obj_dir/seqSim) || {
  echo "$simOut"
  echo "simulation exited with an error"
  exit 1
}
echo "$simOut"
echo "$simOut" | grep -qxF '>>> PASS' && exit 0 || exit 1

// ==== verif/seqTb.sv ====
`timescale 1ns/1ps
`include "sequencer_settings.svh"

module seqTb;

  import seqPkg::*;

  localparam int AW          = `CRAM_ADDR_W;
  localparam int PERIOD      = 40;
  localparam int CRAM_WORDS  = 1 << `CRAM_ADDR_W;
  localparam int NUM_BURSTS  = 16;
  localparam int MAX_BURST   = 80;
  localparam int SWEEP_CASES = 64;
  localparam int WORD_BOUND  = 20;
  // Credit window, random bursts, the select sweep and the nested call program
  localparam int TOTAL_WORDS = `CREDIT_MAX + NUM_BURSTS * MAX_BURST + SWEEP_CASES * 4 + 40;
  // Store fill, resets, register reloads and readback run with the sequencer stopped
  localparam int SETUP_CYCLES = 2 * CRAM_WORDS + 100 * NUM_BURSTS + 12 * SWEEP_CASES;
  localparam int WATCHDOG_NS  = (SETUP_CYCLES + TOTAL_WORDS * WORD_BOUND) * PERIOD;

  logic CLK = 1'b0;
  logic RESET, cramWe, opLoad, flagLoad, diagAddrLoad, run, creditReturn;
  logic [AW-1:0] cramWAddr, opDispatch, diagAddrIn, uAddr, diagData;
  logic [`FLAG_W-1:0] flags;
  logic [`PAYLOAD_W-1:0] uPayload;
  logic [1:0] diagSel;
  logic uValid, uParity;
  microWord cramWData;

  // Reference model state
  microWord modelMem [CRAM_WORDS];
  logic [AW-1:0] mCr, mOp, mDiag;
  logic [`FLAG_W-1:0] mFlags;
  logic [AW-1:0] stk [`STACK_DEPTH];
  logic [`STACK_PTR_W-1:0] sPtr;
  logic [`STACK_CNT_W-1:0] sCnt;
  int mCredits, issued, owed, retDelay, burstTarget;
  int wordErrors, diagErrors, creditErrors;
  bit consumerOn;
  logic [31:0] lfsr = 32'hb59e;

  always #(PERIOD / 2) CLK = ~CLK;

  microSequencer DUT (
    .CLK(CLK), .RESET(RESET), .cramWe(cramWe), .cramWAddr(cramWAddr), .cramWData(cramWData),
    .opLoad(opLoad), .opDispatch(opDispatch), .flagLoad(flagLoad), .flags(flags),
    .diagAddrLoad(diagAddrLoad), .diagAddrIn(diagAddrIn), .run(run),
    .creditReturn(creditReturn), .diagSel(diagSel), .uValid(uValid), .uAddr(uAddr),
    .uPayload(uPayload), .uParity(uParity), .diagData(diagData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic microWord makeWord(input logic [AW-1:0] j, input seqMode m,
                                        input logic [`PAYLOAD_W-1:0] p);
    microWord w;
    w.jump = j;
    w.mode = m;
    w.sel = selField'(5'(randBits(5)));
    w.payload = p;
    return w;
  endfunction

  function automatic logic [AW-1:0] modelTop();
    logic [`STACK_PTR_W-1:0] below;
    below = (sPtr == '0) ? `STACK_PTR_W'(`STACK_DEPTH - 1) : sPtr - 1'b1;
    return (sCnt == '0) ? '0 : stk[below];
  endfunction

  // Shift code 3 keeps the whole source and the others place its low nibble
  function automatic logic [AW-1:0] modelDispatch(input selField s);
    logic [AW-1:0] src [8];
    logic [AW-1:0] top;
    top = modelTop();
    src[0] = mDiag;
    src[1] = mOp;
    src[2] = AW'(mOp[3:0]);
    src[3] = AW'(mFlags[3:0]);
    src[4] = AW'(mFlags[7:4]);
    src[5] = AW'(mFlags[11:8]);
    src[6] = AW'(mFlags[15:12]);
    src[7] = AW'(top[3:0]);
    if (s.disp.dispShift == 2'd3) return src[s.disp.dispSrc];
    if (s.disp.dispShift == 2'd0) return src[s.disp.dispSrc] & AW'(15);
    if (s.disp.dispShift == 2'd1) return (src[s.disp.dispSrc] & AW'(15)) << 4;
    return (src[s.disp.dispSrc] & AW'(15)) << 7;
  endfunction

  task automatic resetModel();
    mCr = '0;
    mOp = '0;
    mFlags = '0;
    mDiag = '0;
    sPtr = '0;
    sCnt = '0;
    mCredits = `CREDIT_MAX;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input logic [AW-1:0] expAddr, actAddr,
                           input logic [`PAYLOAD_W-1:0] expPay, actPay,
                           input logic expPar, actPar);
    if (actAddr !== expAddr || actPay !== expPay || actPar !== expPar) begin
      $display("error %s: expected addr %h pay %h par %b, actual addr %h pay %h par %b",
               name, expAddr, expPay, expPar, actAddr, actPay, actPar);
      wordErrors++;
    end
  endtask

  task automatic checkDiag(input string name, input logic [AW-1:0] expected, actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      diagErrors++;
    end
  endtask

  task automatic checkCredit(input string name, input logic [`CREDIT_W-1:0] expected, actual);
    if (actual !== expected) begin
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
      creditErrors++;
    end
  endtask

  // Compare one issued word with the model, then walk the model to its next address
  task automatic expectIssuedWord();
    microWord w;
    logic [AW-1:0] top;
    w = modelMem[mCr];
    top = modelTop();
    checkWord($sformatf("word %0d", issued), mCr, uAddr, w.payload, uPayload,
              ^{w.mode, w.sel}, uParity);
    case (w.mode)
      DISPATCH: mCr = w.jump | modelDispatch(w.sel);
      SKIP:     mCr = w.jump | AW'(mFlags[w.sel.skip.skipCond] ^ w.sel.skip.skipInvert);
      CALL: begin
        stk[sPtr] = mCr;
        sPtr = (sPtr == `STACK_PTR_W'(`STACK_DEPTH - 1)) ? '0 : sPtr + 1'b1;
        if (sCnt != `STACK_CNT_W'(`STACK_DEPTH)) sCnt = sCnt + 1'b1;
        mCr = w.jump;
      end
      RETURN: begin
        mCr = w.jump | top;
        if (sCnt != '0) begin
          sPtr = (sPtr == '0) ? `STACK_PTR_W'(`STACK_DEPTH - 1) : sPtr - 1'b1;
          sCnt = sCnt - 1'b1;
        end
      end
      FORCE:   mCr = '1;
      default: mCr = w.jump;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle step, sampled and driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic stepCycle();
    logic expIssue;
    @(negedge CLK);
    expIssue = run && (mCredits > 0);
    checkCredit("issue decision", `CREDIT_W'(expIssue), `CREDIT_W'(uValid));
    if (expIssue) mCredits--;
    if (creditReturn) mCredits++;
    if (uValid === 1'b1) begin
      expectIssuedWord();
      issued++;
      owed++;
      if (owed > `CREDIT_MAX) begin
        $display("more words outstanding (%0d) than credits granted", owed);
        creditErrors++;
      end
    end
    // Consumer hands back one credit per word after a random delay
    if (consumerOn && owed > 0 && retDelay == 0) begin
      creditReturn = 1'b1;
      owed--;
      retDelay = int'(randBits(3));
    end else begin
      creditReturn = 1'b0;
      if (retDelay > 0) retDelay--;
    end
    if (run && issued >= burstTarget) run = 1'b0;
  endtask

  task automatic applyReset();
    RESET = 1'b1;
    repeat (4) stepCycle();
    RESET = 1'b0;
    resetModel();
  endtask

  task automatic storeWrite(input logic [AW-1:0] a, input microWord w);
    stepCycle();
    cramWe = 1'b1;
    cramWAddr = a;
    cramWData = w;
    modelMem[a] = w;
  endtask

  task automatic reloadRegs();
    stepCycle();
    cramWe = 1'b0;
    opDispatch = AW'(randBits(AW));
    flags = `FLAG_W'(randBits(`FLAG_W));
    diagAddrIn = AW'(randBits(AW));
    {opLoad, flagLoad, diagAddrLoad} = 3'b111;
    mOp = opDispatch;
    mFlags = flags;
    mDiag = diagAddrIn;
    stepCycle();
    {opLoad, flagLoad, diagAddrLoad} = 3'b000;
  endtask

  task automatic readbackDiag();
    logic [AW-1:0] expected [4];
    expected[0] = mCr;
    expected[1] = modelTop();
    expected[2] = AW'(sCnt);
    expected[3] = modelDispatch(modelMem[mCr].sel);
    for (int s = 0; s < 4; s++) begin
      diagSel = 2'(s);
      stepCycle();
      checkDiag($sformatf("diag select %0d", s), expected[s], diagData);
    end
  endtask

  task automatic runBurst(input int n);
    int waited;
    waited = 0;
    burstTarget = issued + n;
    run = 1'b1;
    while (issued < burstTarget && waited < n * WORD_BOUND) begin
      stepCycle();
      waited++;
    end
    if (issued < burstTarget) begin
      $display("burst stalled after %0d of %0d words", n - (burstTarget - issued), n);
      creditErrors++;
    end
    run = 1'b0;
  endtask

  task automatic drainCredits();
    int waited;
    waited = 0;
    while ((owed > 0 || creditReturn) && waited < 200) begin
      stepCycle();
      waited++;
    end
    if (owed > 0) begin
      $display("consumer still holds %0d credits after draining", owed);
      creditErrors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int start;
    microWord probe;
    seqMode probeMode;
    {RESET, cramWe, opLoad, flagLoad, diagAddrLoad, run, creditReturn} = 7'b1000000;
    {cramWAddr, opDispatch, diagAddrIn, flags, diagSel} = '0;
    cramWData = '0;
    {wordErrors, diagErrors, creditErrors, issued, owed, retDelay, burstTarget} = '0;
    consumerOn = 1'b0;
    resetModel();
    applyReset();
    diagSel = 2'd0;
    stepCycle();
    checkDiag("crAddr after reset", '0, diagData);
    diagSel = 2'd2;
    stepCycle();
    checkDiag("stack count after reset", '0, diagData);

    for (int a = 0; a < CRAM_WORDS; a++) begin
      storeWrite(AW'(a), makeWord(AW'(randBits(AW)), seqMode'(3'(randBits(3) % 6)),
                                  `PAYLOAD_W'(randBits(`PAYLOAD_W))));
    end
    reloadRegs();

    // Without returns only the reset credits may issue
    start = issued;
    burstTarget = issued + 1000;
    run = 1'b1;
    repeat (`CREDIT_MAX + 8) stepCycle();
    run = 1'b0;
    checkCredit("words issued without returns", `CREDIT_W'(`CREDIT_MAX),
                `CREDIT_W'((issued - start) > 7 ? 7 : issued - start));
    consumerOn = 1'b1;
    drainCredits();

    for (int b = 0; b < NUM_BURSTS; b++) begin
      reloadRegs();
      readbackDiag();
      runBurst(16 + int'(randBits(6)));
      drainCredits();
    end

    // Every select code read as dispatch and as skip, after a call that leaves 5 on top
    for (int c = 0; c < SWEEP_CASES; c++) begin
      applyReset();
      if (c < SWEEP_CASES / 2) begin
        probeMode = DISPATCH;
      end else begin
        probeMode = SKIP;
      end
      storeWrite(AW'(0), makeWord(AW'('h1f5), NEXT_J, `PAYLOAD_W'(c)));
      storeWrite(AW'('h1f5), makeWord(AW'('h1f6), CALL, `PAYLOAD_W'(c)));
      probe = makeWord(AW'(0), probeMode, `PAYLOAD_W'(c));
      probe.sel = selField'(5'(c));
      storeWrite(AW'('h1f6), probe);
      reloadRegs();
      runBurst(4);
      drainCredits();
    end

    // Eleven nested calls, then returns past the bottom of the stack
    applyReset();
    for (int i = 0; i < 11; i++) begin
      storeWrite(AW'(i), makeWord(AW'(i + 1), CALL, `PAYLOAD_W'(i)));
    end
    storeWrite(AW'(11), makeWord(AW'('h400), RETURN, `PAYLOAD_W'('hbeef)));
    for (int i = 0; i < 16; i++) begin
      storeWrite(AW'('h400 + i), makeWord(AW'('h400), RETURN, `PAYLOAD_W'('h100 + i)));
    end
    reloadRegs();
    runBurst(11);
    readbackDiag();
    runBurst(20);
    readbackDiag();
    drainCredits();

    $display("errors: words %0d, diagnostics %0d, credits %0d",
             wordErrors, diagErrors, creditErrors);
    if (wordErrors + diagErrors + creditErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/seqPkg.sv
logic/cramStore.sv
logic/dispatchCapture.sv
logic/returnStack.sv
logic/addressSequencer.sv
logic/issueCredit.sv
logic/microSequencer.sv
verif/seqTb.sv
